// ==== include/pmac_defs.svh ====
// sizes and line codes for the preemptable transmit path
// buffer depths must stay powers of two, min fragment is fixed at build time
`ifndef PMAC_DEFS_SVH
`define PMAC_DEFS_SVH

`define PMAC_BUF_DEPTH    2048   // byte buffer entries
`define PMAC_READY_LIMIT  1500   // fill above this drops ready
`define PMAC_DESC_DEPTH   16     // frames queued at once
`define PMAC_MIN_FRAG     46     // min bytes on either side of a cut

// start-of-frame smd, rotated per frame
`define PMAC_SMD_S0  8'he6
`define PMAC_SMD_S1  8'h4c
`define PMAC_SMD_S2  8'h7f
`define PMAC_SMD_S3  8'hb3
// continuation smd, same rotation index as smd-s
`define PMAC_SMD_C0  8'h61
`define PMAC_SMD_C1  8'h52
`define PMAC_SMD_C2  8'h9e
`define PMAC_SMD_C3  8'h2a
// fragment count codes
`define PMAC_FRA_0   8'he6
`define PMAC_FRA_1   8'h4c
`define PMAC_FRA_2   8'h7f
`define PMAC_FRA_3   8'hb3
`endif

// ==== verilog/pmac_pkg.sv ====
// types shared by the pmac transmit stages
// data path is one byte wide, lengths up to 64k bytes
package pmac_pkg;

    // one payload byte
    typedef logic [7:0] byte_t;

    // byte count of a frame or fragment
    typedef logic [15:0] len_t;

    // ethertype as given by the upper layer
    typedef logic [15:0] etype_t;

    // one entry per buffered frame
    typedef struct packed {
        len_t   len;    // whole frame length in bytes
        etype_t etype;  // type seen on first byte
    } frame_desc_t;

    // rotation index for smd and fragment codes, wraps at 4
    typedef logic [1:0] code_idx_t;

endpackage

// ==== verilog/pmac_if.sv ====
// internal links between the three transmit stages
// all signals are single cycle strobes or fwft heads, no handshake
`timescale 1ns/1ps

////////////////////////////////////////////////////////////
// ingress buffers to scheduler
////////////////////////////////////////////////////////////
interface buf_if import pmac_pkg::*;;
    logic        desc_avail;  // descriptor queue not empty
    frame_desc_t desc;        // head descriptor
    logic        desc_pop;    // take head descriptor
    byte_t       byte_data;   // head byte
    logic        byte_pop;    // take head byte

    modport src (output desc_avail, desc, byte_data, input desc_pop, byte_pop);
    modport dst (input desc_avail, desc, byte_data, output desc_pop, byte_pop);
endinterface

////////////////////////////////////////////////////////////
// scheduler to framer
////////////////////////////////////////////////////////////
interface seg_if import pmac_pkg::*;;
    logic   seg_start;  // first byte of a fragment
    logic   seg_valid;  // byte on seg_data
    byte_t  seg_data;
    logic   seg_end;    // last byte of a fragment
    logic   seg_cont;   // fragment continues a cut frame
    logic   seg_final;  // with seg_end, fragment closes the frame
    len_t   seg_len;    // with seg_end, bytes in this fragment
    etype_t seg_type;

    modport src (
        output seg_start, seg_valid, seg_data, seg_end,
        output seg_cont, seg_final, seg_len, seg_type
    );
    modport dst (
        input seg_start, seg_valid, seg_data, seg_end,
        input seg_cont, seg_final, seg_len, seg_type
    );
endinterface

// ==== verilog/pmac_sync_fifo.sv ====
// fwft circular buffer, head always on o_data
// DEPTH must be a power of two, caller must not push when full
`timescale 1ns/1ps

module pmac_sync_fifo #(
    parameter type T     = logic [7:0],
    parameter int  DEPTH = 16
) (
    input  logic                       i_clk,
    input  logic                       i_rst,
    input  logic                       i_push,
    input  T                           i_data,
    input  logic                       i_pop,
    output T                           o_data,
    output logic                       o_empty,
    output logic [$clog2(DEPTH+1)-1:0] o_count
);

    localparam int AW = $clog2(DEPTH);

    T               mem [DEPTH];
    logic [AW-1:0]  wr_ptr;
    logic [AW-1:0]  rd_ptr;

    assign o_data  = mem[rd_ptr];   // fall through
    assign o_empty = (o_count == '0);

    always_ff @(posedge i_clk) begin
        if (i_push) begin
            mem[wr_ptr] <= i_data;
        end
    end

    always_ff @(posedge i_clk or posedge i_rst) begin
        if (i_rst) begin
            wr_ptr  <= '0;
            rd_ptr  <= '0;
            o_count <= '0;
        end else begin
            if (i_push) wr_ptr <= wr_ptr + 1'b1;  // wraps on power of two
            if (i_pop)  rd_ptr <= rd_ptr + 1'b1;
            case ({i_push, i_pop})
                2'b10:   o_count <= o_count + 1'b1;
                2'b01:   o_count <= o_count - 1'b1;
                default: o_count <= o_count;      // both or neither
            endcase
        end
    end

    // overflow would overwrite the head the reader still needs
    a_no_push_full: assert property (@(posedge i_clk) disable iff (i_rst)
        i_push && !i_pop |-> o_count < DEPTH)
        else $error("fifo push while full");

    a_no_pop_empty: assert property (@(posedge i_clk) disable iff (i_rst)
        i_pop |-> !o_empty)
        else $error("fifo pop while empty");

endmodule

// ==== verilog/pmac_ingress.sv ====
// first stage, frames need at least one byte and end with i_tx_last
// upper layer holds data while o_tx_ready is low
`timescale 1ns/1ps
`include "pmac_defs.svh"

module pmac_ingress import pmac_pkg::*; (
    input  logic   i_clk,
    input  logic   i_rst,
    input  byte_t  i_tx_data,
    input  etype_t i_tx_type,
    input  logic   i_tx_last,
    input  logic   i_tx_valid,
    output logic   o_tx_ready,
    buf_if.src     bus
);

    logic [$clog2(`PMAC_BUF_DEPTH+1)-1:0] byte_count;
    len_t        r_len;        // bytes of current frame so far
    etype_t      r_type;       // type latched on first byte
    logic        desc_push;
    logic        desc_empty;
    frame_desc_t desc_in;

    // data bytes, stored on the edge that sees valid
    pmac_sync_fifo #(.T(byte_t), .DEPTH(`PMAC_BUF_DEPTH)) u_byte_fifo (
        .i_clk   (i_clk),
        .i_rst   (i_rst),
        .i_push  (i_tx_valid),
        .i_data  (i_tx_data),
        .i_pop   (bus.byte_pop),
        .o_data  (bus.byte_data),
        .o_empty (),
        .o_count (byte_count)
    );

    // one descriptor per frame, pushed with last
    pmac_sync_fifo #(.T(frame_desc_t), .DEPTH(`PMAC_DESC_DEPTH)) u_desc_fifo (
        .i_clk   (i_clk),
        .i_rst   (i_rst),
        .i_push  (desc_push),
        .i_data  (desc_in),
        .i_pop   (bus.desc_pop),
        .o_data  (bus.desc),
        .o_empty (desc_empty),
        .o_count ()
    );

    assign desc_push      = i_tx_valid && i_tx_last;
    assign bus.desc_avail = !desc_empty;   // visible the cycle after last
    assign o_tx_ready     = (byte_count <= `PMAC_READY_LIMIT);

    always_comb begin
        desc_in.len   = r_len + 16'd1;                        // count this byte too
        desc_in.etype = (r_len == '0) ? i_tx_type : r_type;  // one byte frame
    end

    always_ff @(posedge i_clk or posedge i_rst) begin
        if (i_rst) begin
            r_len <= '0;
        end else if (i_tx_valid) begin
            r_len <= i_tx_last ? '0 : r_len + 16'd1;
        end
    end

    always_ff @(posedge i_clk) begin
        if (i_tx_valid && r_len == '0) r_type <= i_tx_type;
    end

endmodule

// ==== verilog/pmac_tx_scheduler.sv ====
// second stage, one byte per cycle with no stall once a fragment starts
// a cut needs PMAC_MIN_FRAG bytes sent in the fragment and left in the frame
`timescale 1ns/1ps
`include "pmac_defs.svh"

module pmac_tx_scheduler import pmac_pkg::*; (
    input  logic i_clk,
    input  logic i_rst,
    buf_if.dst   bus,
    input  logic i_emac_busy,
    input  logic i_emac_apply,
    input  logic i_rx_ready,
    output logic o_pmac_apply,
    output logic o_pmac_busy,
    seg_if.src   seg
);

    localparam len_t MIN_FRAG = len_t'(`PMAC_MIN_FRAG);

    logic   r_armed;      // apply was high last cycle
    logic   r_sending;    // fragment in progress after its first byte
    logic   r_pend_cont;  // remainder pending or being sent
    len_t   r_remain;     // frame bytes not yet sent
    len_t   r_sent;       // bytes sent in this fragment
    etype_t r_type;

    logic   pending;
    logic   start_now;
    logic   start_new;
    logic   sending;
    len_t   cur_remain;
    len_t   cur_sent;
    len_t   after;
    logic   last_byte;
    logic   preempt;
    logic   frag_end;

    ////////////////////////////////////////////////////////////
    // arbitration with the express mac
    ////////////////////////////////////////////////////////////
    assign pending   = bus.desc_avail || r_pend_cont;
    // start only if emac stayed idle since our apply
    assign start_now = r_armed && !r_sending && !i_emac_busy && pending;
    assign start_new = start_now && !r_pend_cont;    // fresh frame, take descriptor
    assign sending   = start_now || r_sending;

    assign o_pmac_apply = pending && !sending && !i_emac_busy && i_rx_ready;
    assign o_pmac_busy  = sending;

    ////////////////////////////////////////////////////////////
    // per byte counts and the cut decision
    ////////////////////////////////////////////////////////////
    assign cur_remain = start_new ? bus.desc.len : r_remain;  // incl this byte
    assign cur_sent   = start_now ? 16'd1 : r_sent + 16'd1;  // incl this byte
    assign after      = cur_remain - 16'd1;
    assign last_byte  = (after == '0);

    assign preempt  = i_emac_apply && (cur_sent >= MIN_FRAG) && (after >= MIN_FRAG);
    assign frag_end = last_byte || preempt;

    // queue pops
    assign bus.desc_pop = start_new;
    assign bus.byte_pop = sending;

    // fragment stream to the framer
    assign seg.seg_start = start_now;
    assign seg.seg_valid = sending;
    assign seg.seg_data  = bus.byte_data;
    assign seg.seg_end   = sending && frag_end;
    assign seg.seg_cont  = sending && r_pend_cont;  // flag stays up across the remainder
    assign seg.seg_final = sending && last_byte;
    assign seg.seg_len   = cur_sent;
    assign seg.seg_type  = start_new ? bus.desc.etype : r_type;

    always_ff @(posedge i_clk or posedge i_rst) begin
        if (i_rst) begin
            r_armed     <= 1'b0;
            r_sending   <= 1'b0;
            r_pend_cont <= 1'b0;
            r_remain    <= '0;
            r_sent      <= '0;
        end else begin
            r_armed <= o_pmac_apply;
            if (sending) begin
                r_remain  <= after;
                r_sent    <= cur_sent;
                r_sending <= !frag_end;
                if (frag_end) begin
                    r_pend_cont <= !last_byte;  // cut leaves a remainder
                end
            end
        end
    end

    always_ff @(posedge i_clk) begin
        if (start_new) r_type <= bus.desc.etype;  // held for continuations
    end

    // emac idle and line side ready in the apply cycle, emac still idle at start
    a_start_emac_idle: assert property (@(posedge i_clk) disable iff (i_rst)
        seg.seg_start |-> !i_emac_busy && $past(!i_emac_busy && i_rx_ready))
        else $error("pmac started while the express mac held the line");

    // every continuation keeps at least a minimum fragment
    a_cont_min_len: assert property (@(posedge i_clk) disable iff (i_rst)
        seg.seg_end && seg.seg_cont |-> seg.seg_len >= MIN_FRAG)
        else $error("continuation fragment shorter than the minimum");

endmodule

// ==== verilog/pmac_framer.sv ====
// third stage, every output registered one cycle behind seg_if
// o_send_len and o_crc are valid with o_send_last, len_vld a cycle later
`timescale 1ns/1ps
`include "pmac_defs.svh"

module pmac_framer import pmac_pkg::*; (
    input  logic   i_clk,
    input  logic   i_rst,
    seg_if.dst     seg,
    output byte_t  o_send_data,
    output logic   o_send_valid,
    output logic   o_send_last,
    output etype_t o_send_type,
    output len_t   o_send_len,
    output logic   o_send_len_vld,
    output byte_t  o_smd,
    output logic   o_smd_vld,
    output byte_t  o_fra,
    output logic   o_fra_vld,
    output logic   o_crc
);

    code_idx_t r_frame_idx;  // moves after each final fragment
    code_idx_t r_frag_idx;   // moves after each continuation

    function automatic byte_t smd_s(input code_idx_t idx);
        case (idx)
            2'd0:    smd_s = `PMAC_SMD_S0;
            2'd1:    smd_s = `PMAC_SMD_S1;
            2'd2:    smd_s = `PMAC_SMD_S2;
            default: smd_s = `PMAC_SMD_S3;
        endcase
    endfunction

    function automatic byte_t smd_c(input code_idx_t idx);
        case (idx)
            2'd0:    smd_c = `PMAC_SMD_C0;
            2'd1:    smd_c = `PMAC_SMD_C1;
            2'd2:    smd_c = `PMAC_SMD_C2;
            default: smd_c = `PMAC_SMD_C3;
        endcase
    endfunction

    function automatic byte_t fra_code(input code_idx_t idx);
        case (idx)
            2'd0:    fra_code = `PMAC_FRA_0;
            2'd1:    fra_code = `PMAC_FRA_1;
            2'd2:    fra_code = `PMAC_FRA_2;
            default: fra_code = `PMAC_FRA_3;
        endcase
    endfunction

    always_ff @(posedge i_clk or posedge i_rst) begin
        if (i_rst) begin
            o_send_valid   <= 1'b0;
            o_send_last    <= 1'b0;
            o_smd_vld      <= 1'b0;
            o_fra_vld      <= 1'b0;
            o_send_len_vld <= 1'b0;
            r_frame_idx    <= '0;
            r_frag_idx     <= '0;
        end else begin
            o_send_valid   <= seg.seg_valid;
            o_send_last    <= seg.seg_end;
            o_smd_vld      <= seg.seg_start;
            o_fra_vld      <= seg.seg_start && seg.seg_cont;
            o_send_len_vld <= o_send_last;  // len settled by now
            if (seg.seg_end && seg.seg_final) r_frame_idx <= r_frame_idx + 1'b1;
            if (seg.seg_start && !seg.seg_cont) begin
                r_frag_idx <= '0;            // new frame
            end else if (seg.seg_end && seg.seg_cont) begin
                r_frag_idx <= r_frag_idx + 1'b1;
            end
        end
    end

    always_ff @(posedge i_clk) begin
        o_send_data <= seg.seg_data;
        o_send_type <= seg.seg_type;
        if (seg.seg_start) o_smd <= seg.seg_cont ? smd_c(r_frame_idx) : smd_s(r_frame_idx);
        if (seg.seg_start && seg.seg_cont) o_fra <= fra_code(r_frag_idx);
        if (seg.seg_end) begin
            o_send_len <= seg.seg_len;
            o_crc      <= seg.seg_final;  // 0 means mcrc on a cut
        end
    end

endmodule

// ==== verilog/pmac_tx_top.sv ====
// preemptable mac transmit path, ingress then scheduler then framer
// express mac arbitration through the apply/busy levels only
`timescale 1ns/1ps

module pmac_tx_top import pmac_pkg::*; (
    input  logic   i_clk,
    input  logic   i_rst,
    // upper layer
    input  byte_t  i_tx_data,
    input  etype_t i_tx_type,
    input  logic   i_tx_last,
    input  logic   i_tx_valid,
    output logic   o_tx_ready,
    // express mac
    input  logic   i_emac_busy,
    input  logic   i_emac_apply,
    output logic   o_pmac_apply,
    output logic   o_pmac_busy,
    // next stage
    input  logic   i_rx_ready,
    output byte_t  o_send_data,
    output logic   o_send_valid,
    output logic   o_send_last,
    output etype_t o_send_type,
    output len_t   o_send_len,
    output logic   o_send_len_vld,
    output byte_t  o_smd,
    output logic   o_smd_vld,
    output byte_t  o_fra,
    output logic   o_fra_vld,
    output logic   o_crc
);

    buf_if u_buf ();
    seg_if u_seg ();

    pmac_ingress u_ingress (
        .i_clk, .i_rst, .i_tx_data, .i_tx_type, .i_tx_last, .i_tx_valid, .o_tx_ready,
        .bus (u_buf.src)
    );

    pmac_tx_scheduler u_sched (
        .i_clk, .i_rst, .bus (u_buf.dst), .i_emac_busy, .i_emac_apply, .i_rx_ready,
        .o_pmac_apply, .o_pmac_busy, .seg (u_seg.src)
    );

    pmac_framer u_framer (
        .i_clk, .i_rst, .seg (u_seg.dst), .o_send_data, .o_send_valid, .o_send_last,
        .o_send_type, .o_send_len, .o_send_len_vld, .o_smd, .o_smd_vld,
        .o_fra, .o_fra_vld, .o_crc
    );

endmodule

// ==== testbench/tb_pmac_tx.sv ====
// self-checking testbench for pmac_tx_top, run from the project root
// frames come from testbench/pmac_input.txt, express mac is a small stub
`timescale 1ns/1ps
`include "pmac_defs.svh"

module tb_pmac_tx import pmac_pkg::*; ();

    localparam logic [31:0] SEED      = 32'd34800;
    localparam int          TIMEOUT   = 20000;  // cycles per wait
    localparam int          EMAC_HOLD = 12;     // express frame length in cycles

    logic   i_clk, i_rst;
    byte_t  i_tx_data;
    etype_t i_tx_type;
    logic   i_tx_last, i_tx_valid, o_tx_ready;
    logic   i_emac_busy, i_emac_apply, o_pmac_apply, o_pmac_busy;
    logic   i_rx_ready, o_send_valid, o_send_last, o_send_len_vld;
    byte_t  o_send_data, o_smd, o_fra;
    etype_t o_send_type;
    len_t   o_send_len;
    logic   o_smd_vld, o_fra_vld, o_crc;

    // one entry per line of the data file
    string  t_name [$];
    int     t_len [$], t_seed [$], t_req [$], t_bp [$], t_frags [$], t_len0 [$];
    etype_t t_type [$];
    bit     t_drop [$];

    byte_t smd_s_tab [4] = '{`PMAC_SMD_S0, `PMAC_SMD_S1, `PMAC_SMD_S2, `PMAC_SMD_S3};
    byte_t smd_c_tab [4] = '{`PMAC_SMD_C0, `PMAC_SMD_C1, `PMAC_SMD_C2, `PMAC_SMD_C3};
    byte_t fra_tab   [4] = '{`PMAC_FRA_0, `PMAC_FRA_1, `PMAC_FRA_2, `PMAC_FRA_3};

    int   err_count = 0, tests_pass = 0, tests_fail = 0, frames_done = 0;
    bit   aborted = 1'b0;
    bit   line_wanted = 1'b0;   // express mac wants the line
    bit   frag_closed = 1'b0;   // fragment ended while it waited
    logic prev_emac_busy = 1'b0, prev_pmac_busy = 1'b0;
    logic prev_pmac_apply = 1'b0, prev_send_last = 1'b0;

    pmac_tx_top i_dut (.*);

    initial begin
        i_clk = 1'b0;
        forever #4 i_clk = ~i_clk;
    end

    function automatic logic [31:0] lcg_next(input logic [31:0] s);
        return s * 32'd1103515245 + 32'd12345;
    endfunction

    ////////////////////////////////////////////////////////////
    // compare tasks
    ////////////////////////////////////////////////////////////
    task automatic check_byte(input string tn, what, input byte_t exp, act);
        if (exp !== act) begin
            $display("mismatch %s %s: expected %h actual %h", tn, what, exp, act);
            err_count++;
        end
    endtask

    task automatic check_code(input string tn, what, input byte_t exp, act);
        if (exp !== act) begin
            $display("mismatch %s %s code: expected %h actual %h", tn, what, exp, act);
            err_count++;
        end
    endtask

    task automatic check_len(input string tn, what, input len_t exp, act);
        if (exp !== act) begin
            $display("mismatch %s %s: expected %0d actual %0d", tn, what, exp, act);
            err_count++;
        end
    endtask

    task automatic check_type(input string tn, what, input etype_t exp, act);
        if (exp !== act) begin
            $display("mismatch %s %s: expected %h actual %h", tn, what, exp, act);
            err_count++;
        end
    endtask

    task automatic check_flag(input string tn, what, input logic exp, act);
        if (exp !== act) begin
            $display("mismatch %s %s: expected %b actual %b", tn, what, exp, act);
            err_count++;
        end
    endtask

    task automatic read_tests();
        int    fd, n, len, typ, seed, req, bp, frags, len0;
        string line, nm;
        fd = $fopen("testbench/pmac_input.txt", "r");
        if (fd == 0) begin
            $display("could not open testbench/pmac_input.txt");
            aborted = 1'b1;
            return;
        end
        while (!$feof(fd)) begin
            line = "";
            n = $fgets(line, fd);
            if (n > 1 && line[0] != "#") begin   // skip header and blank lines
                n = $sscanf(line, "%s %d %h %d %d %d %d %d",
                            nm, len, typ, seed, req, bp, frags, len0);
                if (n == 8) begin
                    t_name.push_back(nm);
                    t_len.push_back(len);
                    t_type.push_back(etype_t'(typ));
                    t_seed.push_back(seed);
                    t_req.push_back(req);
                    t_bp.push_back(bp);
                    t_frags.push_back(frags);
                    t_len0.push_back(len0);
                    t_drop.push_back(1'b0);
                end
            end
        end
        $fclose(fd);
    endtask

    ////////////////////////////////////////////////////////////
    // upper layer, drives on the falling edge
    ////////////////////////////////////////////////////////////
    task automatic write_frame(input int t);
        logic [31:0] s;
        int          k, cyc;
        s = SEED ^ t_seed[t];
        i_rx_ready = (t_bp[t] == 0);   // hold the line side to fill the buffer
        for (k = 0; k < t_len[t]; k++) begin
            s = lcg_next(s);
            cyc = 0;
            while (!o_tx_ready && !aborted) begin
                t_drop[t]  = 1'b1;
                i_rx_ready = 1'b1;    // drain so ready comes back
                i_tx_valid = 1'b0;
                @(negedge i_clk);
                cyc++;
                if (cyc > TIMEOUT) begin
                    $display("timeout waiting for o_tx_ready to rise in %s", t_name[t]);
                    aborted = 1'b1;
                end
            end
            i_tx_data  = s[23:16];
            i_tx_type  = t_type[t];
            i_tx_last  = (k == t_len[t] - 1);
            i_tx_valid = 1'b1;
            @(negedge i_clk);
        end
        i_tx_valid = 1'b0;
        i_tx_last  = 1'b0;
    endtask

    task automatic write_all();
        int t, cyc;
        for (t = 0; t < t_name.size() && !aborted; t++) begin
            cyc = 0;
            // back-pressure group starts from an empty buffer
            while (t_bp[t] != 0 && (t == 0 || t_bp[t-1] == 0) && frames_done < t) begin
                @(negedge i_clk);
                cyc++;
                if (cyc > TIMEOUT) begin
                    $display("timeout waiting for earlier frames to drain before %s",
                             t_name[t]);
                    aborted = 1'b1;
                    return;
                end
            end
            write_frame(t);
        end
    endtask

    // express mac stub, apply until the fragment ends, then a fixed busy time
    task automatic run_emac_stub();
        forever begin
            @(negedge i_clk);
            if (line_wanted && frag_closed) begin
                i_emac_apply = 1'b0;
                i_emac_busy  = 1'b1;
                repeat (EMAC_HOLD) @(negedge i_clk);
                i_emac_busy  = 1'b0;
                line_wanted  = 1'b0;
                frag_closed  = 1'b0;
            end else if (line_wanted) begin
                i_emac_apply = 1'b1;
            end
        end
    endtask

    // arbitration, o_send lags the scheduler by one cycle
    always @(posedge i_clk) begin
        if (!i_rst) begin
            if (o_send_valid && prev_emac_busy) begin
                $display("o_send_valid seen while i_emac_busy was high");
                err_count++;
            end
            if (o_pmac_apply && (o_pmac_busy || i_emac_busy || !i_rx_ready)) begin
                $display("o_pmac_apply high while a fragment, the express mac or the line held");
                err_count++;
            end
            // start comes one cycle after apply unless emac took the line
            check_flag("arbitration", "fragment start", prev_pmac_apply && !i_emac_busy,
                       o_pmac_busy && !prev_pmac_busy);
            check_flag("arbitration", "o_pmac_busy window", prev_pmac_busy, o_send_valid);
            check_flag("framing", "o_send_len_vld", prev_send_last, o_send_len_vld);
        end
        prev_emac_busy  <= i_emac_busy;
        prev_pmac_busy  <= o_pmac_busy;
        prev_pmac_apply <= o_pmac_apply;
        prev_send_last  <= o_send_last;
    end

    ////////////////////////////////////////////////////////////
    // output monitor, one frame at a time
    ////////////////////////////////////////////////////////////
    task automatic check_frame(input int t);
        logic [31:0] s;
        int          n, frag, fbytes, len0, last_len, cyc, errs0;
        bit          done;
        errs0 = err_count;
        s = SEED ^ t_seed[t];
        n        = 0;
        frag     = 0;
        fbytes   = 0;
        len0     = 0;
        last_len = 0;
        cyc      = 0;
        done     = 1'b0;
        while (!done && !aborted) begin
            @(posedge i_clk);
            if (o_smd_vld) begin
                check_code(t_name[t], "smd", (frag == 0) ? smd_s_tab[frames_done % 4]
                                                         : smd_c_tab[frames_done % 4], o_smd);
                check_flag(t_name[t], "o_fra_vld", frag != 0, o_fra_vld);
                if (frag != 0) check_code(t_name[t], "fra", fra_tab[(frag - 1) % 4], o_fra);
                check_type(t_name[t], "type", t_type[t], o_send_type);
            end else begin
                check_flag(t_name[t], "o_fra_vld", 1'b0, o_fra_vld);
            end
            if (o_send_valid) begin
                s = lcg_next(s);
                check_byte(t_name[t], "data", s[23:16], o_send_data);
                n++;
                fbytes++;
                if (n == t_req[t]) line_wanted = 1'b1;  // request point reached
            end
            if (o_send_last) begin
                check_flag(t_name[t], "crc", n == t_len[t], o_crc);
                if (frag == 0) len0 = fbytes;
                frag++;
                last_len = fbytes;
                fbytes   = 0;
                if (line_wanted) frag_closed = 1'b1;
            end
            if (o_send_len_vld) begin
                check_len(t_name[t], "fragment length", len_t'(last_len), o_send_len);
                done = (n >= t_len[t]);
            end
            cyc++;
            if (cyc > TIMEOUT) begin
                $display("timeout waiting for the output of frame %s", t_name[t]);
                aborted = 1'b1;
            end
        end
        check_len(t_name[t], "fragment count", len_t'(t_frags[t]), len_t'(frag));
        check_len(t_name[t], "first fragment", len_t'(t_len0[t]), len_t'(len0));
        if (t_bp[t] == 2 && !t_drop[t]) begin
            $display("o_tx_ready never dropped while %s filled the buffer", t_name[t]);
            err_count++;
        end
        frames_done++;
        if (err_count == errs0 && !aborted) begin
            tests_pass++;
            $display("test %s passed, %0d fragments", t_name[t], frag);
        end else begin
            tests_fail++;
            $display("test %s failed with %0d errors", t_name[t], err_count - errs0);
        end
    endtask

    initial begin
        int t;
        i_rst        = 1'b1;
        i_tx_data    = '0;
        i_tx_type    = '0;
        i_tx_last    = 1'b0;
        i_tx_valid   = 1'b0;
        i_emac_busy  = 1'b0;
        i_emac_apply = 1'b0;
        i_rx_ready   = 1'b1;
        read_tests();
        repeat (3) @(negedge i_clk);
        i_rst = 1'b0;
        check_flag("reset", "o_tx_ready", 1'b1, o_tx_ready);
        check_flag("reset", "o_pmac_apply", 1'b0, o_pmac_apply);
        check_flag("reset", "o_pmac_busy", 1'b0, o_pmac_busy);
        check_flag("reset", "o_send_valid", 1'b0, o_send_valid);
        fork
            write_all();
            run_emac_stub();
        join_none
        for (t = 0; t < t_name.size() && !aborted; t++) begin
            check_frame(t);
        end
        $display("summary: %0d tests, %0d passed, %0d failed, %0d errors",
                 t_name.size(), tests_pass, tests_fail, err_count);
        if (err_count == 0 && !aborted && t_name.size() > 0 && tests_pass == t_name.size())
            $display("No errors");
        else
            $display("Errors found");
        $finish;
    end

endmodule

// ==== testbench/pmac_input.txt ====
# name length type_hex seed req_idx(-1 none) bp(0 off, 1 hold line, 2 hold and expect drop)
# then expected fragment count and first fragment length
plain_64 64 0800 1 -1 0 1 64
plain_one 1 0806 2 -1 0 1 1
plain_100 100 86dd 3 -1 0 1 100
plain_1200 1200 0800 4 -1 0 1 1200
pre_mid 200 88f7 5 60 0 2 62
pre_early 150 0800 6 5 0 2 46
late_req 120 0800 7 80 0 1 120
short_frame 80 8100 8 10 0 1 80
pre_edge_sent 92 0800 9 20 0 2 46
pre_edge_left 300 86dd 10 252 0 2 254
bp_first 800 0800 11 -1 1 1 800
bp_second 800 0800 12 -1 2 1 800
after_bp 64 0806 13 -1 0 1 64

// ==== project.f ====
+incdir+include
verilog/pmac_pkg.sv
verilog/pmac_if.sv
verilog/pmac_sync_fifo.sv
verilog/pmac_ingress.sv
verilog/pmac_tx_scheduler.sv
verilog/pmac_framer.sv
verilog/pmac_tx_top.sv
testbench/tb_pmac_tx.sv
